/* design/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// full operand and result width
`define ALU_XLEN 64

// one datapath half; stage one does the low half, stage two the high half
`define ALU_HALF 32

// c, s, z, v
`define ALU_FLAG_W 4

// shift amount taken from the low bits of b
`define ALU_SHAMT_W 6

`endif

/* design/alu_pkg.sv */
package alu_pkg;

  // opcodes, immediate forms already folded into b
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_MOV = 4'd2,
    OP_SHL = 4'd3,
    OP_SHR = 4'd4,
    OP_SAR = 4'd5,
    OP_AND = 4'd6,
    OP_XOR = 4'd7,
    OP_OR  = 4'd8,
    OP_SXT = 4'd9   // mode in b[1:0]
  } alu_op_e;

  // predicate codes, tested against the flag register
  typedef enum logic [3:0] {
    CC_EQ = 4'd0,
    CC_NE = 4'd1,
    CC_CS = 4'd2,   // no borrow after sub
    CC_CC = 4'd3,
    CC_MI = 4'd4,
    CC_PL = 4'd5,
    CC_VS = 4'd6,
    CC_VC = 4'd7,
    CC_HI = 4'd8,
    CC_LS = 4'd9,
    CC_GE = 4'd10,
    CC_LT = 4'd11,
    CC_GT = 4'd12,
    CC_LE = 4'd13,
    CC_AL = 4'd14,
    CC_NV = 4'd15
  } cond_e;

  typedef struct packed {
    logic c;  // carry out of bit 63
    logic s;  // result bit 63
    logic z;  // whole result zero
    logic v;  // signed overflow
  } flags_t;

endpackage

/* design/alu_lo_stage.sv */
`timescale 1ns/10ps
`include "alu_settings.svh"

module alu_lo_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  alu_pkg::alu_op_e          op,
  input  alu_pkg::cond_e            cond,
  input  logic                      set_flags,
  input  logic [`ALU_XLEN-1:0]      a,
  input  logic [`ALU_XLEN-1:0]      b,
  output logic                      s2_valid,
  output alu_pkg::alu_op_e          s2_op,
  output alu_pkg::cond_e            s2_cond,
  output logic                      s2_set_flags,
  output logic [`ALU_XLEN-1:0]      s2_a,
  output logic [`ALU_XLEN-1:0]      s2_b,
  output logic [`ALU_HALF-1:0]      s2_lo,
  output logic                      s2_carry
);

  logic                     is_sub;
  logic [`ALU_HALF-1:0]     b_add;
  logic [`ALU_HALF:0]       sum_lo;
  logic [`ALU_SHAMT_W-1:0]  shamt;
  logic [`ALU_XLEN-1:0]     shl_full;
  logic [`ALU_XLEN-1:0]     shr_full;
  logic [`ALU_XLEN-1:0]     sar_full;
  logic [`ALU_HALF-1:0]     sxt_lo;
  logic [`ALU_HALF-1:0]     lo;

  // sub is a + ~b + 1, carry out means no borrow
  assign is_sub = (op == alu_pkg::OP_SUB);
  assign b_add  = is_sub ? ~b[`ALU_HALF-1:0] : b[`ALU_HALF-1:0];
  assign sum_lo = {1'b0, a[`ALU_HALF-1:0]} + {1'b0, b_add} + {{`ALU_HALF{1'b0}}, is_sub};

  // shifts need all of a, bits from the upper half can land here
  assign shamt    = b[`ALU_SHAMT_W-1:0];
  assign shl_full = a << shamt;
  assign shr_full = a >> shamt;
  assign sar_full = $signed(a) >>> shamt;

  always_comb begin
    case (b[1:0])
      2'd0:    sxt_lo = {{24{a[7]}}, a[7:0]};
      2'd1:    sxt_lo = {{16{a[15]}}, a[15:0]};
      2'd2:    sxt_lo = a[31:0];
      default: sxt_lo = {a[7:0], a[15:8], a[23:16], a[31:24]};  // byte swap
    endcase
  end

  always_comb begin
    case (op)
      alu_pkg::OP_ADD: lo = sum_lo[`ALU_HALF-1:0];
      alu_pkg::OP_SUB: lo = sum_lo[`ALU_HALF-1:0];
      alu_pkg::OP_MOV: lo = b[`ALU_HALF-1:0];
      alu_pkg::OP_SHL: lo = shl_full[`ALU_HALF-1:0];
      alu_pkg::OP_SHR: lo = shr_full[`ALU_HALF-1:0];
      alu_pkg::OP_SAR: lo = sar_full[`ALU_HALF-1:0];
      alu_pkg::OP_AND: lo = a[`ALU_HALF-1:0] & b[`ALU_HALF-1:0];
      alu_pkg::OP_XOR: lo = a[`ALU_HALF-1:0] ^ b[`ALU_HALF-1:0];
      alu_pkg::OP_OR:  lo = a[`ALU_HALF-1:0] | b[`ALU_HALF-1:0];
      alu_pkg::OP_SXT: lo = sxt_lo;
      default:         lo = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= in_valid;
    end
  end

  // payload for stage two
  always_ff @(posedge clk) begin
    s2_op        <= op;
    s2_cond      <= cond;
    s2_set_flags <= set_flags;
    s2_a         <= a;
    s2_b         <= b;
    s2_lo        <= lo;
    s2_carry     <= sum_lo[`ALU_HALF];  // only meaningful for add/sub
  end

endmodule

/* design/alu_hi_stage.sv */
`timescale 1ns/10ps
`include "alu_settings.svh"

module alu_hi_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      s2_valid,
  input  alu_pkg::alu_op_e          s2_op,
  input  alu_pkg::cond_e            s2_cond,
  input  logic                      s2_set_flags,
  input  logic [`ALU_XLEN-1:0]      s2_a,
  input  logic [`ALU_XLEN-1:0]      s2_b,
  input  logic [`ALU_HALF-1:0]      s2_lo,
  input  logic                      s2_carry,
  input  logic                      cond_true,
  output alu_pkg::cond_e            cond,
  output logic                      out_valid,
  output logic [`ALU_XLEN-1:0]      result,
  output logic                      executed,
  output alu_pkg::flags_t           flags_out,
  output logic                      upd_en,
  output alu_pkg::flags_t           new_flags,
  input  alu_pkg::flags_t           cur_flags
);

  logic                     is_arith;
  logic                     is_sub;
  logic [`ALU_HALF-1:0]     b_add;
  logic [`ALU_HALF:0]       sum_hi;
  logic                     ovf;
  logic [`ALU_SHAMT_W-1:0]  shamt;
  logic [`ALU_XLEN-1:0]     shl_full;
  logic [`ALU_XLEN-1:0]     shr_full;
  logic [`ALU_XLEN-1:0]     sar_full;
  logic [`ALU_HALF-1:0]     hi;
  logic [`ALU_XLEN-1:0]     full;
  alu_pkg::flags_t          calc_flags;

  assign cond = s2_cond;  // evaluated in flag_unit against the live flags

  assign is_sub   = (s2_op == alu_pkg::OP_SUB);
  assign is_arith = (s2_op == alu_pkg::OP_ADD) || is_sub;

  // upper half of the adder, carry-in from stage one
  assign b_add  = is_sub ? ~s2_b[`ALU_XLEN-1:`ALU_HALF] : s2_b[`ALU_XLEN-1:`ALU_HALF];
  assign sum_hi = {1'b0, s2_a[`ALU_XLEN-1:`ALU_HALF]} + {1'b0, b_add}
                + {{`ALU_HALF{1'b0}}, s2_carry};
  assign ovf    = (s2_a[`ALU_XLEN-1] == b_add[`ALU_HALF-1])
               && (sum_hi[`ALU_HALF-1] != s2_a[`ALU_XLEN-1]);

  assign shamt    = s2_b[`ALU_SHAMT_W-1:0];
  assign shl_full = s2_a << shamt;
  assign shr_full = s2_a >> shamt;
  assign sar_full = $signed(s2_a) >>> shamt;

  always_comb begin
    case (s2_op)
      alu_pkg::OP_ADD: hi = sum_hi[`ALU_HALF-1:0];
      alu_pkg::OP_SUB: hi = sum_hi[`ALU_HALF-1:0];
      alu_pkg::OP_MOV: hi = s2_b[`ALU_XLEN-1:`ALU_HALF];
      alu_pkg::OP_SHL: hi = shl_full[`ALU_XLEN-1:`ALU_HALF];
      alu_pkg::OP_SHR: hi = shr_full[`ALU_XLEN-1:`ALU_HALF];
      alu_pkg::OP_SAR: hi = sar_full[`ALU_XLEN-1:`ALU_HALF];
      alu_pkg::OP_AND: hi = s2_a[`ALU_XLEN-1:`ALU_HALF] & s2_b[`ALU_XLEN-1:`ALU_HALF];
      alu_pkg::OP_XOR: hi = s2_a[`ALU_XLEN-1:`ALU_HALF] ^ s2_b[`ALU_XLEN-1:`ALU_HALF];
      alu_pkg::OP_OR:  hi = s2_a[`ALU_XLEN-1:`ALU_HALF] | s2_b[`ALU_XLEN-1:`ALU_HALF];
      // low half already sign extended, swap mode zero extends
      alu_pkg::OP_SXT: hi = (s2_b[1:0] == 2'd3) ? '0 : {`ALU_HALF{s2_lo[`ALU_HALF-1]}};
      default:         hi = '0;
    endcase
  end

  assign full = {hi, s2_lo};

  always_comb begin
    calc_flags.c = is_arith & sum_hi[`ALU_HALF];
    calc_flags.s = full[`ALU_XLEN-1];
    calc_flags.z = ~|full;
    calc_flags.v = is_arith & ovf;
  end

  // flag write lands on the same edge as the result register
  assign upd_en    = s2_valid & cond_true & s2_set_flags;
  assign new_flags = calc_flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    executed  <= cond_true;
    result    <= cond_true ? full : s2_a;         // false predicate passes a
    flags_out <= cond_true ? calc_flags : cur_flags;
  end

endmodule

/* design/flag_unit.sv */
`timescale 1ns/10ps
`include "alu_settings.svh"

module flag_unit (
  input  logic                clk,
  input  logic                rst,
  input  alu_pkg::cond_e      cond,
  input  logic                upd_en,
  input  alu_pkg::flags_t     new_flags,
  output logic                cond_true,
  output alu_pkg::flags_t     cur_flags
);

  logic [`ALU_FLAG_W-1:0] flag_q;
  logic                   sv_eq;

  always_ff @(posedge clk) begin
    if (rst) begin
      flag_q <= '0;
    end else if (upd_en) begin
      flag_q <= new_flags;
    end
  end

  assign cur_flags = alu_pkg::flags_t'(flag_q);

  assign sv_eq = (cur_flags.s == cur_flags.v);  // signed compare helper

  // decoded against the register value before this edge's write
  always_comb begin
    case (cond)
      alu_pkg::CC_EQ: cond_true = cur_flags.z;
      alu_pkg::CC_NE: cond_true = ~cur_flags.z;
      alu_pkg::CC_CS: cond_true = cur_flags.c;
      alu_pkg::CC_CC: cond_true = ~cur_flags.c;
      alu_pkg::CC_MI: cond_true = cur_flags.s;
      alu_pkg::CC_PL: cond_true = ~cur_flags.s;
      alu_pkg::CC_VS: cond_true = cur_flags.v;
      alu_pkg::CC_VC: cond_true = ~cur_flags.v;
      alu_pkg::CC_HI: cond_true = cur_flags.c & ~cur_flags.z;
      alu_pkg::CC_LS: cond_true = ~cur_flags.c | cur_flags.z;
      alu_pkg::CC_GE: cond_true = sv_eq;
      alu_pkg::CC_LT: cond_true = ~sv_eq;
      alu_pkg::CC_GT: cond_true = ~cur_flags.z & sv_eq;
      alu_pkg::CC_LE: cond_true = cur_flags.z | ~sv_eq;
      alu_pkg::CC_AL: cond_true = 1'b1;
      alu_pkg::CC_NV: cond_true = 1'b0;
      default:        cond_true = 1'b0;
    endcase
  end

endmodule

/* design/split_alu.sv */
`timescale 1ns/10ps
`include "alu_settings.svh"

module split_alu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  alu_pkg::alu_op_e      op,
  input  alu_pkg::cond_e        cond,
  input  logic                  set_flags,
  input  logic [`ALU_XLEN-1:0]  a,
  input  logic [`ALU_XLEN-1:0]  b,
  output logic                  out_valid,
  output logic [`ALU_XLEN-1:0]  result,
  output logic                  executed,
  output alu_pkg::flags_t       flags_out
);

  // stage one to stage two
  logic                   s2_valid;
  alu_pkg::alu_op_e       s2_op;
  alu_pkg::cond_e         s2_cond;
  logic                   s2_set_flags;
  logic [`ALU_XLEN-1:0]   s2_a;
  logic [`ALU_XLEN-1:0]   s2_b;
  logic [`ALU_HALF-1:0]   s2_lo;
  logic                   s2_carry;

  // stage two to flag register
  alu_pkg::cond_e         hi_cond;
  logic                   cond_true;
  logic                   upd_en;
  alu_pkg::flags_t        new_flags;
  alu_pkg::flags_t        cur_flags;

  alu_lo_stage u_lo (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .op           (op),
    .cond         (cond),
    .set_flags    (set_flags),
    .a            (a),
    .b            (b),
    .s2_valid     (s2_valid),
    .s2_op        (s2_op),
    .s2_cond      (s2_cond),
    .s2_set_flags (s2_set_flags),
    .s2_a         (s2_a),
    .s2_b         (s2_b),
    .s2_lo        (s2_lo),
    .s2_carry     (s2_carry)
  );

  alu_hi_stage u_hi (
    .clk          (clk),
    .rst          (rst),
    .s2_valid     (s2_valid),
    .s2_op        (s2_op),
    .s2_cond      (s2_cond),
    .s2_set_flags (s2_set_flags),
    .s2_a         (s2_a),
    .s2_b         (s2_b),
    .s2_lo        (s2_lo),
    .s2_carry     (s2_carry),
    .cond_true    (cond_true),
    .cond         (hi_cond),
    .out_valid    (out_valid),
    .result       (result),
    .executed     (executed),
    .flags_out    (flags_out),
    .upd_en       (upd_en),
    .new_flags    (new_flags),
    .cur_flags    (cur_flags)
  );

  flag_unit u_flags (
    .clk       (clk),
    .rst       (rst),
    .cond      (hi_cond),
    .upd_en    (upd_en),
    .new_flags (new_flags),
    .cond_true (cond_true),
    .cur_flags (cur_flags)
  );

endmodule

/* dv/alu_checker.sv */
`timescale 1ns/10ps
`include "alu_settings.svh"

module alu_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic                  out_valid,
  input  logic [`ALU_XLEN-1:0]  result,
  input  logic                  executed,
  input  alu_pkg::flags_t       flags_out
);

  logic [`ALU_XLEN-1:0] exp_res_q[$];
  logic                 exp_exe_q[$];
  logic [3:0]           exp_flg_q[$];

  logic [1:0] vhist;  // in_valid seen at the last two edges
  int         seen_cnt = 0;
  int         pass_cnt = 0;
  int         fail_cnt = 0;

  task automatic push_exp(input logic [`ALU_XLEN-1:0] res, input logic exe,
                          input logic [3:0] flg);
    exp_res_q.push_back(res);
    exp_exe_q.push_back(exe);
    exp_flg_q.push_back(flg);
  endtask

  always @(posedge clk) begin
    logic [`ALU_XLEN-1:0] er;
    logic                 ee;
    logic [3:0]           ef;
    logic [3:0]           got_f;
    string                msg;
    if (rst) begin
      vhist <= 2'b00;
      if (out_valid) begin
        $display("out_valid went high during reset at %0t", $time);
        fail_cnt = fail_cnt + 1;
      end
    end else begin
      vhist <= {vhist[0], in_valid};
      if (out_valid != vhist[1]) begin
        $display("out_valid did not follow in_valid by two cycles at %0t", $time);
        fail_cnt = fail_cnt + 1;
      end
      if (out_valid) begin
        if (exp_res_q.size() == 0) begin
          $display("out_valid seen at %0t with no instruction waiting for a result", $time);
          fail_cnt = fail_cnt + 1;
        end else begin
          er    = exp_res_q.pop_front();
          ee    = exp_exe_q.pop_front();
          ef    = exp_flg_q.pop_front();
          got_f = flags_out;
          msg   = "";
          if (result !== er) begin
            msg = {msg, $sformatf(" result %h, expected %h", result, er)};
          end
          if (executed !== ee) begin
            msg = {msg, $sformatf(" executed %b, expected %b", executed, ee)};
          end
          if (got_f !== ef) begin
            msg = {msg, $sformatf(" flags cszv %b, expected %b", got_f, ef)};
          end
          if (msg != "") begin
            $display("FAIL %0t: row %0d%s", $time, seen_cnt, msg);
            fail_cnt = fail_cnt + 1;
          end else begin
            $display("pass %0t: row %0d", $time, seen_cnt);
            pass_cnt = pass_cnt + 1;
          end
          seen_cnt = seen_cnt + 1;
        end
      end
    end
  end

endmodule

/* dv/tb_split_alu.sv */
`timescale 1ns/10ps
`include "alu_settings.svh"

module tb_split_alu;

  localparam int N_RAND = 200;
  localparam int N_MAX  = 256;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  in_valid;
  alu_pkg::alu_op_e      op;
  alu_pkg::cond_e        cond;
  logic                  set_flags;
  logic [`ALU_XLEN-1:0]  a;
  logic [`ALU_XLEN-1:0]  b;
  logic                  out_valid;
  logic [`ALU_XLEN-1:0]  result;
  logic                  executed;
  alu_pkg::flags_t       flags_out;

  // stimulus table
  alu_pkg::alu_op_e      t_op   [N_MAX];
  alu_pkg::cond_e        t_cond [N_MAX];
  logic                  t_sf   [N_MAX];
  logic [`ALU_XLEN-1:0]  t_a    [N_MAX];
  logic [`ALU_XLEN-1:0]  t_b    [N_MAX];
  logic [`ALU_XLEN-1:0]  t_res  [N_MAX];
  logic                  t_exe  [N_MAX];
  logic [3:0]            t_flg  [N_MAX];
  int                    n_rows = 0;
  logic                  table_done = 1'b0;

  logic [31:0] lfsr = 32'd94632;
  logic [3:0]  m_flags;  // model flag register as {c, s, z, v}

  always #5 clk = ~clk;

  split_alu u_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .cond      (cond),
    .set_flags (set_flags),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result),
    .executed  (executed),
    .flags_out (flags_out)
  );

  alu_checker u_chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .executed  (executed),
    .flags_out (flags_out)
  );

  task automatic add_row(input alu_pkg::alu_op_e o, input alu_pkg::cond_e c, input logic sf,
                         input logic [63:0] ra, input logic [63:0] rb,
                         input logic [63:0] res, input logic exe, input logic [3:0] flg);
    t_op[n_rows]   = o;
    t_cond[n_rows] = c;
    t_sf[n_rows]   = sf;
    t_a[n_rows]    = ra;
    t_b[n_rows]    = rb;
    t_res[n_rows]  = res;
    t_exe[n_rows]  = exe;
    t_flg[n_rows]  = flg;
    n_rows = n_rows + 1;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  function automatic logic cond_holds(input alu_pkg::cond_e c, input logic [3:0] f);
    logic fc;
    logic fs;
    logic fz;
    logic fv;
    fc = f[3];
    fs = f[2];
    fz = f[1];
    fv = f[0];
    case (c)
      alu_pkg::CC_EQ: return fz;
      alu_pkg::CC_NE: return !fz;
      alu_pkg::CC_CS: return fc;
      alu_pkg::CC_CC: return !fc;
      alu_pkg::CC_MI: return fs;
      alu_pkg::CC_PL: return !fs;
      alu_pkg::CC_VS: return fv;
      alu_pkg::CC_VC: return !fv;
      alu_pkg::CC_HI: return fc && !fz;
      alu_pkg::CC_LS: return !fc || fz;
      alu_pkg::CC_GE: return fs == fv;
      alu_pkg::CC_LT: return fs != fv;
      alu_pkg::CC_GT: return !fz && (fs == fv);
      alu_pkg::CC_LE: return fz || (fs != fv);
      alu_pkg::CC_AL: return 1'b1;
      default:        return 1'b0;
    endcase
  endfunction

  task automatic model_exec(input alu_pkg::alu_op_e o, input alu_pkg::cond_e c,
                            input logic sf, input logic [63:0] ra, input logic [63:0] rb,
                            output logic [63:0] res, output logic exe,
                            output logic [3:0] flg);
    logic [64:0] sum;
    logic [63:0] r;
    logic        fc;
    logic        fv;
    sum = '0;
    fc  = 1'b0;
    fv  = 1'b0;
    case (o)
      alu_pkg::OP_ADD: begin
        sum = {1'b0, ra} + {1'b0, rb};
        r   = sum[63:0];
        fc  = sum[64];
        fv  = (ra[63] == rb[63]) && (r[63] != ra[63]);
      end
      alu_pkg::OP_SUB: begin
        sum = {1'b0, ra} + {1'b0, ~rb} + 65'd1;
        r   = sum[63:0];
        fc  = sum[64];  // no borrow
        fv  = (ra[63] != rb[63]) && (r[63] != ra[63]);
      end
      alu_pkg::OP_MOV: r = rb;
      alu_pkg::OP_SHL: r = ra << rb[5:0];
      alu_pkg::OP_SHR: r = ra >> rb[5:0];
      alu_pkg::OP_SAR: r = $signed(ra) >>> rb[5:0];
      alu_pkg::OP_AND: r = ra & rb;
      alu_pkg::OP_XOR: r = ra ^ rb;
      alu_pkg::OP_OR:  r = ra | rb;
      default: begin
        case (rb[1:0])
          2'd0:    r = {{56{ra[7]}}, ra[7:0]};
          2'd1:    r = {{48{ra[15]}}, ra[15:0]};
          2'd2:    r = {{32{ra[31]}}, ra[31:0]};
          default: r = {32'd0, ra[7:0], ra[15:8], ra[23:16], ra[31:24]};
        endcase
      end
    endcase
    exe = cond_holds(c, m_flags);
    if (exe) begin
      res = r;
      flg = {fc, r[63], (r == 64'd0), fv};
      if (sf) m_flags = flg;
    end else begin
      res = ra;
      flg = m_flags;
    end
  endtask

  task automatic build_table();
    logic [63:0] rop;
    logic [63:0] rcond;
    logic [63:0] rsf;
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] res;
    logic        exe;
    logic [3:0]  flg;
    logic [3:0]  opn;
    // predication and flags from a zeroed flag register
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_EQ, 1, 64'd5, 64'd7, 64'd5, 0, 4'b0000);
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_AL, 1, 64'h0000_0000_FFFF_FFFF, 64'd1,
            64'h0000_0001_0000_0000, 1, 4'b0000);
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_AL, 1, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'd0,
            1, 4'b1010);
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_EQ, 1, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1,
            64'h8000_0000_0000_0000, 1, 4'b0101);
    add_row(alu_pkg::OP_SUB, alu_pkg::CC_VS, 1, 64'd0, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF,
            1, 4'b0100);
    add_row(alu_pkg::OP_SUB, alu_pkg::CC_MI, 1, 64'd10, 64'd3, 64'd7, 1, 4'b1000);
    add_row(alu_pkg::OP_SUB, alu_pkg::CC_CS, 1, 64'h8000_0000_0000_0000, 64'd1,
            64'h7FFF_FFFF_FFFF_FFFF, 1, 4'b1001);
    add_row(alu_pkg::OP_SUB, alu_pkg::CC_LT, 1, 64'd3, 64'd3, 64'd0, 1, 4'b1010);
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_HI, 1, 64'd1, 64'd1, 64'd1, 0, 4'b1010);
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_LS, 0, 64'd1, 64'd2, 64'd3, 1, 4'b0000);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_NE, 1, 64'd9, 64'd4, 64'd9, 0, 4'b1010);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_CC, 1, 64'd9, 64'd4, 64'd9, 0, 4'b1010);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_PL, 1, 64'd9, 64'h8000_0000_0000_0000,
            64'h8000_0000_0000_0000, 1, 4'b0100);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_VC, 1, 64'd1, 64'd0, 64'd0, 1, 4'b0010);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_GE, 1, 64'd1, 64'h0123_4567_89AB_CDEF,
            64'h0123_4567_89AB_CDEF, 1, 4'b0000);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_GT, 1, 64'd1, 64'hFFFF_FFFF_FFFF_FFFE,
            64'hFFFF_FFFF_FFFF_FFFE, 1, 4'b0100);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_LE, 1, 64'd2, 64'd5, 64'd5, 1, 4'b0000);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_NV, 1, 64'd6, 64'd7, 64'd6, 0, 4'b0000);
    add_row(alu_pkg::OP_ADD, alu_pkg::CC_CC, 1, 64'd0, 64'd0, 64'd0, 1, 4'b0010);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_MI, 1, 64'd4, 64'd5, 64'd4, 0, 4'b0010);
    add_row(alu_pkg::OP_MOV, alu_pkg::CC_EQ, 1, 64'd4, 64'd5, 64'd5, 1, 4'b0000);
    // shifts with the flag register left at zero
    add_row(alu_pkg::OP_SHL, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd0,
            64'h8000_0000_0000_0001, 1, 4'b0100);
    add_row(alu_pkg::OP_SHL, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd31,
            64'h0000_0000_8000_0000, 1, 4'b0000);
    add_row(alu_pkg::OP_SHL, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd32,
            64'h0000_0001_0000_0000, 1, 4'b0000);
    add_row(alu_pkg::OP_SHL, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd63,
            64'h8000_0000_0000_0000, 1, 4'b0100);
    add_row(alu_pkg::OP_SHR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd0,
            64'h8000_0000_0000_0001, 1, 4'b0100);
    add_row(alu_pkg::OP_SHR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd31,
            64'h0000_0001_0000_0000, 1, 4'b0000);
    add_row(alu_pkg::OP_SHR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd32,
            64'h0000_0000_8000_0000, 1, 4'b0000);
    add_row(alu_pkg::OP_SHR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd63,
            64'd1, 1, 4'b0000);
    add_row(alu_pkg::OP_SAR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd0,
            64'h8000_0000_0000_0001, 1, 4'b0100);
    add_row(alu_pkg::OP_SAR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd31,
            64'hFFFF_FFFF_0000_0000, 1, 4'b0100);
    add_row(alu_pkg::OP_SAR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd32,
            64'hFFFF_FFFF_8000_0000, 1, 4'b0100);
    add_row(alu_pkg::OP_SAR, alu_pkg::CC_AL, 0, 64'h8000_0000_0000_0001, 64'd63,
            64'hFFFF_FFFF_FFFF_FFFF, 1, 4'b0100);
    // logic ops
    add_row(alu_pkg::OP_AND, alu_pkg::CC_AL, 0, 64'hF0F0_F0F0_0F0F_0F0F,
            64'hFF00_FF00_FF00_FF00, 64'hF000_F000_0F00_0F00, 1, 4'b0100);
    add_row(alu_pkg::OP_XOR, alu_pkg::CC_AL, 0, 64'hF0F0_F0F0_0F0F_0F0F,
            64'hFF00_FF00_FF00_FF00, 64'h0FF0_0FF0_F00F_F00F, 1, 4'b0000);
    add_row(alu_pkg::OP_OR, alu_pkg::CC_AL, 0, 64'hF0F0_F0F0_0F0F_0F0F,
            64'hFF00_FF00_FF00_FF00, 64'hFFF0_FFF0_FF0F_FF0F, 1, 4'b0100);
    add_row(alu_pkg::OP_AND, alu_pkg::CC_AL, 0, 64'hF0F0_F0F0_F0F0_F0F0,
            64'h0F0F_0F0F_0F0F_0F0F, 64'd0, 1, 4'b0010);
    // sign extension modes
    add_row(alu_pkg::OP_SXT, alu_pkg::CC_AL, 0, 64'h1122_3344_8899_AA80, 64'd0,
            64'hFFFF_FFFF_FFFF_FF80, 1, 4'b0100);
    add_row(alu_pkg::OP_SXT, alu_pkg::CC_AL, 0, 64'h1122_3344_8899_AA80, 64'd1,
            64'hFFFF_FFFF_FFFF_AA80, 1, 4'b0100);
    add_row(alu_pkg::OP_SXT, alu_pkg::CC_AL, 0, 64'h1122_3344_8899_AA80, 64'd2,
            64'hFFFF_FFFF_8899_AA80, 1, 4'b0100);
    add_row(alu_pkg::OP_SXT, alu_pkg::CC_AL, 0, 64'h1122_3344_8899_AA80, 64'd3,
            64'h0000_0000_80AA_9988, 1, 4'b0000);
    // random rows continue from the zero flag state above
    m_flags = 4'b0000;
    for (int i = 0; i < N_RAND; i++) begin
      rand_bits(4, rop);
      rand_bits(4, rcond);
      rand_bits(1, rsf);
      rand_bits(64, ra);
      rand_bits(64, rb);
      opn = rop[3:0] % 4'd10;
      model_exec(alu_pkg::alu_op_e'(opn), alu_pkg::cond_e'(rcond[3:0]), rsf[0], ra, rb,
                 res, exe, flg);
      add_row(alu_pkg::alu_op_e'(opn), alu_pkg::cond_e'(rcond[3:0]), rsf[0], ra, rb,
              res, exe, flg);
    end
  endtask

  // watchdog
  initial begin
    wait (table_done);
    #((n_rows + 8 + 20) * 10);
    $display("timed out waiting for results, %0d of %0d rows seen", u_chk.seen_cnt, n_rows);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    op        = alu_pkg::OP_ADD;
    cond      = alu_pkg::CC_AL;
    set_flags = 1'b0;
    a         = '0;
    b         = '0;
    build_table();
    table_done = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #1;
      in_valid  = 1'b1;
      op        = t_op[i];
      cond      = t_cond[i];
      set_flags = t_sf[i];
      a         = t_a[i];
      b         = t_b[i];
      u_chk.push_exp(t_res[i], t_exe[i], t_flg[i]);
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
    while (u_chk.seen_cnt < n_rows) @(posedge clk);
    repeat (3) @(posedge clk);  // catch stray out_valid pulses
    #1;
    $display("rows passed %0d, failed %0d", u_chk.pass_cnt, u_chk.fail_cnt);
    if (u_chk.fail_cnt == 0 && u_chk.pass_cnt == n_rows) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/alu_pkg.sv
design/alu_lo_stage.sv
design/alu_hi_stage.sv
design/flag_unit.sv
design/split_alu.sv
dv/alu_checker.sv
dv/tb_split_alu.sv

/* run.sh */
#!/bin/sh
# build and run the split_alu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_split_alu -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
